// File: include/gpu_defs.svh
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

//////////////////////////////
// Screen geometry
//////////////////////////////
`define GPU_SCREEN_W 32
`define GPU_SCREEN_H 24

`define GPU_X_BITS 5
`define GPU_Y_BITS 5
`define GPU_Z_BITS 8      // Smaller is nearer, all ones is far

`define GPU_RGB_BITS 12   // Three 4-bit channels r, g, b
`define GPU_ID_BITS 16

`define GPU_FB_WORDS 768  // Width times height

`endif

// File: logic/gpu_pkg.sv
`include "gpu_defs.svh"

package gpu_pkg;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////
  typedef struct packed {
    logic [`GPU_X_BITS-1:0] x;
    logic [`GPU_Y_BITS-1:0] y;
    logic [`GPU_Z_BITS-1:0] z;
  } vertex_t;

  typedef struct packed {
    logic [`GPU_ID_BITS-1:0] id;
    vertex_t                 v0;
    vertex_t                 v1;
    vertex_t                 v2;
  } triangle_t;

  typedef struct packed {
    logic [`GPU_X_BITS-1:0]  x;
    logic [`GPU_Y_BITS-1:0]  y;
    logic [`GPU_Z_BITS-1:0]  z;  // Flat triangle depth
    logic [`GPU_ID_BITS-1:0] id;
  } fragment_t;

  typedef struct packed {
    logic [`GPU_X_BITS-1:0]   x;
    logic [`GPU_Y_BITS-1:0]   y;
    logic [`GPU_Z_BITS-1:0]   z;
    logic [`GPU_RGB_BITS-1:0] rgb;
  } pixel_t;

  //////////////////////////////
  // Framebuffer storage
  //////////////////////////////
  typedef struct packed {
    logic [`GPU_Z_BITS-1:0]   z;
    logic [`GPU_RGB_BITS-1:0] rgb;
  } fb_word_t;

endpackage

// File: logic/triangle_assembler.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module triangle_assembler (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               vertex_valid,
  input  gpu_pkg::vertex_t   vertex,
  output logic               vertex_ready,
  output logic               tri_valid,
  output gpu_pkg::triangle_t triangle,
  input  logic               tri_ready,
  input  logic               shader_busy,
  input  logic               fb_ready,
  output logic               idle
);

  import gpu_pkg::*;

  typedef enum logic [1:0] {Vertex1, Vertex2, Vertex3, Present} slot_t;

  slot_t                   state;
  logic [`GPU_ID_BITS-1:0] tri_count;
  logic                    vertex_fire;

  assign vertex_ready = (state != Present) && fb_ready;  // Hold off during clear
  assign vertex_fire  = vertex_valid && vertex_ready;
  assign tri_valid    = (state == Present);

  // Nothing held anywhere in the pipeline
  assign idle = (state == Vertex1) && tri_ready && !shader_busy && fb_ready;

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      state     <= Vertex1;
      tri_count <= '0;
    end else begin
      case (state)
        Vertex1: if (vertex_fire) state <= Vertex2;
        Vertex2: if (vertex_fire) state <= Vertex3;
        Vertex3: if (vertex_fire) state <= Present;
        Present: begin
          if (tri_ready) begin
            state     <= Vertex1;
            tri_count <= tri_count + 1'b1;  // Number advances on transfer
          end
        end
        default: state <= Vertex1;
      endcase
    end
  end

  // Triangle is built in place and stays stable while presented
  always_ff @(posedge gpu_clk) begin
    if (vertex_fire) begin
      case (state)
        Vertex1: triangle.v0 <= vertex;
        Vertex2: triangle.v1 <= vertex;
        Vertex3: begin
          triangle.v2 <= vertex;
          triangle.id <= tri_count;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: logic/rasterizer.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module rasterizer (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               tri_valid,
  input  gpu_pkg::triangle_t triangle,
  output logic               tri_ready,
  output logic               frag_valid,
  output gpu_pkg::fragment_t frag
);

  import gpu_pkg::*;

  localparam int XB = `GPU_X_BITS;
  localparam int YB = `GPU_Y_BITS;

  typedef enum logic [1:0] {Ready, Scan, Drain} scan_state_t;

  scan_state_t state;
  logic        accept;

  // Combinational setup from the offered triangle
  vertex_t                vtx [3];
  logic signed [5:0]      dx_in [3];
  logic signed [5:0]      dy_in [3];
  logic signed [13:0]     area;
  logic [XB-1:0]          bx_min, bx_max;
  logic [YB-1:0]          by_min, by_max;
  logic [`GPU_Z_BITS-1:0] z_min;
  logic                   off_screen;

  // Registered setup and scan position
  logic [XB-1:0]           x_lo, x_hi, cx;
  logic [YB-1:0]           y_hi, cy;
  logic [`GPU_Z_BITS-1:0]  z_flat;
  logic [`GPU_ID_BITS-1:0] tri_id;
  logic [XB-1:0]           ax [3];
  logic [YB-1:0]           ay [3];
  logic signed [5:0]       edx [3];
  logic signed [5:0]       edy [3];

  // Edge evaluation stage
  logic signed [13:0] e_now [3];
  logic signed [13:0] s2_e [3];
  logic               s2_valid;
  logic [XB-1:0]      s2_x;
  logic [YB-1:0]      s2_y;
  logic               all_ge, all_le;

  assign vtx[0]    = triangle.v0;
  assign vtx[1]    = triangle.v1;
  assign vtx[2]    = triangle.v2;
  assign tri_ready = (state == Ready);
  assign accept    = tri_valid && tri_ready;

  //////////////////////////////
  // Triangle setup
  //////////////////////////////
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      dx_in[k] = $signed({1'b0, vtx[(k + 1) % 3].x}) - $signed({1'b0, vtx[k].x});
      dy_in[k] = $signed({1'b0, vtx[(k + 1) % 3].y}) - $signed({1'b0, vtx[k].y});
    end
    area = dx_in[0] * ($signed({1'b0, vtx[2].y}) - $signed({1'b0, vtx[0].y}))
         - dy_in[0] * ($signed({1'b0, vtx[2].x}) - $signed({1'b0, vtx[0].x}));

    bx_min = vtx[0].x;
    bx_max = vtx[0].x;
    by_min = vtx[0].y;
    by_max = vtx[0].y;
    z_min  = vtx[0].z;
    for (int k = 1; k < 3; k++) begin
      if (vtx[k].x < bx_min) bx_min = vtx[k].x;
      if (vtx[k].x > bx_max) bx_max = vtx[k].x;
      if (vtx[k].y < by_min) by_min = vtx[k].y;
      if (vtx[k].y > by_max) by_max = vtx[k].y;
      if (vtx[k].z < z_min) z_min = vtx[k].z;
    end

    if (bx_max > XB'(`GPU_SCREEN_W - 1)) bx_max = XB'(`GPU_SCREEN_W - 1);  // Clamp to screen
    if (by_max > YB'(`GPU_SCREEN_H - 1)) by_max = YB'(`GPU_SCREEN_H - 1);
    off_screen = (bx_min > XB'(`GPU_SCREEN_W - 1)) || (by_min > YB'(`GPU_SCREEN_H - 1));
  end

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      state    <= Ready;
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= (state == Scan);
      case (state)
        Ready: begin
          if (accept) state <= (area == 0 || off_screen) ? Drain : Scan;  // Skip empty work
        end
        Scan: if (cx == x_hi && cy == y_hi) state <= Drain;
        Drain: state <= Ready;  // Last fragment is on the output now
        default: state <= Ready;
      endcase
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (accept) begin
      cx     <= bx_min;
      cy     <= by_min;
      x_lo   <= bx_min;
      x_hi   <= bx_max;
      y_hi   <= by_max;
      z_flat <= z_min;
      tri_id <= triangle.id;
      for (int k = 0; k < 3; k++) begin
        ax[k]  <= vtx[k].x;
        ay[k]  <= vtx[k].y;
        edx[k] <= dx_in[k];
        edy[k] <= dy_in[k];
      end
    end else if (state == Scan) begin
      if (cx == x_hi) begin  // Row-major walk
        cx <= x_lo;
        cy <= cy + 1'b1;
      end else begin
        cx <= cx + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Edge evaluation
  //////////////////////////////
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      e_now[k] = edx[k] * ($signed({1'b0, cy}) - $signed({1'b0, ay[k]}))
               - edy[k] * ($signed({1'b0, cx}) - $signed({1'b0, ax[k]}));
    end
  end

  always_ff @(posedge gpu_clk) begin
    s2_x <= cx;
    s2_y <= cy;
    s2_e <= e_now;
  end

  assign all_ge = (s2_e[0] >= 0) && (s2_e[1] >= 0) && (s2_e[2] >= 0);
  assign all_le = (s2_e[0] <= 0) && (s2_e[1] <= 0) && (s2_e[2] <= 0);

  assign frag_valid = s2_valid && (all_ge || all_le);  // Either winding with edges included
  assign frag       = '{x: s2_x, y: s2_y, z: z_flat, id: tri_id};

endmodule

// File: logic/fragment_shader.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module fragment_shader (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               frag_valid,
  input  gpu_pkg::fragment_t frag,
  output logic               pix_valid,
  output gpu_pkg::pixel_t    pix,
  output logic               shader_busy
);

  import gpu_pkg::*;

  logic [`GPU_RGB_BITS-1:0] base;
  logic [3:0]               dim;
  logic [`GPU_RGB_BITS-1:0] shaded;

  // Depth dimming by the top two z bits
  always_comb begin
    base = frag.id[`GPU_RGB_BITS-1:0];
    dim  = {2'b00, frag.z[`GPU_Z_BITS-1 -: 2]};
    for (int c = 0; c < 3; c++) begin
      if (base[c*4 +: 4] > dim) begin
        shaded[c*4 +: 4] = base[c*4 +: 4] - dim;
      end else begin
        shaded[c*4 +: 4] = 4'd0;  // Saturate
      end
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= frag_valid;
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (frag_valid) begin
      pix <= '{x: frag.x, y: frag.y, z: frag.z, rgb: shaded};
    end
  end

  assign shader_busy = pix_valid;  // Pixel still waiting for its write

endmodule

// File: logic/framebuffer.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module framebuffer (
  input  logic                   gpu_clk,
  input  logic                   rst_in,
  input  logic                   clear,
  input  logic                   swap,
  input  logic                   pix_valid,
  input  gpu_pkg::pixel_t        pix,
  output logic                   fb_ready,
  input  logic [`GPU_X_BITS-1:0] rd_x,
  input  logic [`GPU_Y_BITS-1:0] rd_y,
  output gpu_pkg::fb_word_t      rd_data
);

  import gpu_pkg::*;

  localparam int AB = $clog2(`GPU_FB_WORDS);

  fb_word_t bank [2][`GPU_FB_WORDS];

  logic          front;
  logic          back;
  logic          clearing;
  logic [AB-1:0] clear_addr;
  logic [AB-1:0] pix_addr;
  logic [AB-1:0] rd_addr;
  fb_word_t      stored;
  logic          depth_pass;

  function automatic logic [AB-1:0] fb_addr(input logic [`GPU_X_BITS-1:0] x,
                                            input logic [`GPU_Y_BITS-1:0] y);
    return AB'(y) * AB'(`GPU_SCREEN_W) + AB'(x);
  endfunction

  assign back       = ~front;
  assign fb_ready   = !clearing;
  assign pix_addr   = fb_addr(pix.x, pix.y);
  assign rd_addr    = fb_addr(rd_x, rd_y);
  assign stored     = bank[back][pix_addr];  // Read half of read-compare-write
  assign depth_pass = pix.z < stored.z;      // Ties keep the older pixel

  //////////////////////////////
  // Swap and clear sweep
  //////////////////////////////
  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      front      <= 1'b0;
      clearing   <= 1'b0;
      clear_addr <= '0;
    end else begin
      if (swap) front <= ~front;
      if (clearing) begin
        if (clear_addr == AB'(`GPU_FB_WORDS - 1)) clearing <= 1'b0;
        clear_addr <= clear_addr + 1'b1;
      end else if (clear) begin
        clearing   <= 1'b1;
        clear_addr <= '0;
      end
    end
  end

  //////////////////////////////
  // Banks
  //////////////////////////////
  always_ff @(posedge gpu_clk) begin
    if (clearing) begin
      bank[back][clear_addr] <= '{z: '1, rgb: '0};  // Far and black
    end else if (pix_valid && depth_pass) begin
      bank[back][pix_addr] <= '{z: pix.z, rgb: pix.rgb};
    end
  end

  // Front bank read port
  always_ff @(posedge gpu_clk) begin
    rd_data <= bank[front][rd_addr];
  end

endmodule

// File: logic/gpu_top.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module gpu_top (
  input  logic                   gpu_clk,
  input  logic                   rst_in,
  input  logic                   vertex_valid,
  input  gpu_pkg::vertex_t       vertex,
  output logic                   vertex_ready,
  input  logic                   clear,
  input  logic                   swap,
  input  logic [`GPU_X_BITS-1:0] rd_x,
  input  logic [`GPU_Y_BITS-1:0] rd_y,
  output logic                   idle,
  output gpu_pkg::fb_word_t      rd_data
);

  import gpu_pkg::*;

  triangle_t triangle;
  logic      tri_valid;
  logic      tri_ready;
  fragment_t frag;
  logic      frag_valid;
  pixel_t    pix;
  logic      pix_valid;
  logic      shader_busy;
  logic      fb_ready;

  triangle_assembler triangle_assembler (
    .gpu_clk,
    .rst_in,
    .vertex_valid,
    .vertex,
    .vertex_ready,
    .tri_valid,
    .triangle,
    .tri_ready,
    .shader_busy,
    .fb_ready,
    .idle
  );

  rasterizer rasterizer (
    .gpu_clk,
    .rst_in,
    .tri_valid,
    .triangle,
    .tri_ready,
    .frag_valid,
    .frag
  );

  fragment_shader fragment_shader (
    .gpu_clk,
    .rst_in,
    .frag_valid,
    .frag,
    .pix_valid,
    .pix,
    .shader_busy
  );

  framebuffer framebuffer (
    .gpu_clk,
    .rst_in,
    .clear,
    .swap,
    .pix_valid,
    .pix,
    .fb_ready,
    .rd_x,
    .rd_y,
    .rd_data
  );

endmodule

// File: bench/gpu_tb.sv
`timescale 1ns/1ps
`include "gpu_defs.svh"

module gpu_tb;

  import gpu_pkg::*;

  localparam int NTRI = 14;
  localparam int NROW = 9;
  localparam int W = `GPU_SCREEN_W;
  localparam int H = `GPU_SCREEN_H;

  // x0 y0 x1 y1 x2 y2 z0 z1 z2
  localparam int TRI_TAB [NTRI][9] = '{
    '{ 2,  2, 20,  4,  8, 18, 'h90, 'hA0, 'h88},
    '{ 2,  2,  8, 18, 20,  4, 'h90, 'h88, 'hA0},  // Same triangle in the other winding
    '{ 0,  0, 10, 10, 20, 20, 'h05, 'h05, 'h05},  // Zero area
    '{ 4,  4, 24,  4,  4, 20, 'h60, 'h60, 'h60},
    '{10,  2, 28, 10, 10, 18, 'h30, 'h30, 'h30},
    '{10,  2, 28, 10, 10, 18, 'h30, 'h30, 'h30},
    '{ 4,  4, 24,  4,  4, 20, 'h60, 'h60, 'h60},
    '{10,  2, 28, 10, 10, 18, 'h30, 'h30, 'h30},  // Tie with the earlier one
    '{ 0,  0, 31,  0,  0, 23, 'hF0, 'hF0, 'hF0},
    '{16, 12, 30, 12, 16, 22, 'h50, 'h50, 'h50},
    '{ 0,  0, 31,  0,  0, 23, 'h80, 'h80, 'h80},
    '{31, 23,  0, 23, 31,  0, 'h70, 'h70, 'h70},
    '{ 5,  5, 10,  5,  5, 10, 'h20, 'h20, 'h20},
    '{ 5,  5, 10,  5,  5, 10, 'h20, 'h20, 'h20}
  };

  // clear swap first_tri n_tri probe_x probe_y probe_z probe_rgb
  localparam int SCENE_TAB [NROW][8] = '{
    '{1, 1,  0, 1,  9,  8, 'h88, 'h000},  // Coverage
    '{1, 1,  1, 2, 10, 10, 'h88, 'h000},  // Winding and zero area
    '{1, 1,  3, 2, 12,  8, 'h30, 'h004},  // Depth
    '{1, 1,  5, 3, 12,  8, 'h30, 'h005},  // Depth in the other order with a tie
    '{1, 1,  8, 1,  1,  1, 'hF0, 'h005},  // Shading
    '{1, 0,  9, 1,  1,  1, 'hF0, 'h005},  // Back bank only
    '{0, 1, 10, 0, 18, 14, 'h50, 'h008},
    '{1, 0, 10, 0, 18, 14, 'h50, 'h008},  // Clear hits the back bank only
    '{1, 1, 10, 4,  6,  6, 'h20, 'h00C}
  };

  logic                   gpu_clk = 1'b0;
  logic                   rst_in;
  logic                   vertex_valid;
  vertex_t                vertex;
  logic                   vertex_ready;
  logic                   clear;
  logic                   swap;
  logic [`GPU_X_BITS-1:0] rd_x;
  logic [`GPU_Y_BITS-1:0] rd_y;
  logic                   idle;
  fb_word_t               rd_data;

  fb_word_t mbank [2][`GPU_FB_WORDS];  // Reference banks
  logic     mfront;

  always #50 gpu_clk = ~gpu_clk;

  gpu_top dut0 (
    .gpu_clk,
    .rst_in,
    .vertex_valid,
    .vertex,
    .vertex_ready,
    .clear,
    .swap,
    .rd_x,
    .rd_y,
    .idle,
    .rd_data
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input fb_word_t actual, input fb_word_t expected, input int x,
                            input int y);
    if (actual !== expected) begin
      abort_run($sformatf("Error rd_data at (%0d,%0d) expected %h actual %h",
                          x, y, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("%s stayed %s when it should not", name, actual ? "high" : "low"));
    end
  endtask

  ////////////////////////////////
  // Reference frame model
  ////////////////////////////////
  function automatic bit covers(input int t, input int px, input int py);
    int xs [3];
    int ys [3];
    int e [3];
    int j;
    for (int k = 0; k < 3; k++) begin
      xs[k] = TRI_TAB[t][2*k];
      ys[k] = TRI_TAB[t][2*k+1];
    end
    if ((xs[1] - xs[0]) * (ys[2] - ys[0]) == (ys[1] - ys[0]) * (xs[2] - xs[0])) return 1'b0;
    for (int k = 0; k < 3; k++) begin
      j = (k + 1) % 3;
      e[k] = (xs[j] - xs[k]) * (py - ys[k]) - (ys[j] - ys[k]) * (px - xs[k]);
    end
    return (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) || (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
  endfunction

  function automatic logic [`GPU_RGB_BITS-1:0] shade(input int id,
                                                     input logic [`GPU_Z_BITS-1:0] z);
    logic [`GPU_RGB_BITS-1:0] base;
    logic [`GPU_RGB_BITS-1:0] out;
    logic [3:0]               dim;
    base = `GPU_RGB_BITS'(id);
    dim  = {2'b00, z[`GPU_Z_BITS-1 -: 2]};
    for (int c = 0; c < 3; c++) begin
      out[c*4 +: 4] = (base[c*4 +: 4] > dim) ? base[c*4 +: 4] - dim : 4'd0;
    end
    return out;
  endfunction

  task automatic draw_expected(input int t, input int id);
    logic [`GPU_Z_BITS-1:0] zmin;
    int                     a;
    zmin = 8'(TRI_TAB[t][6]);
    for (int k = 7; k < 9; k++) begin
      if (8'(TRI_TAB[t][k]) < zmin) zmin = 8'(TRI_TAB[t][k]);
    end
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        a = y * W + x;
        if (covers(t, x, y) && zmin < mbank[!mfront][a].z) begin
          mbank[!mfront][a] = '{z: zmin, rgb: shade(id, zmin)};
        end
      end
    end
  endtask

  task automatic blank_back();
    for (int a = 0; a < `GPU_FB_WORDS; a++) mbank[!mfront][a] = '{z: '1, rgb: '0};
  endtask

  ////////////////////////////////
  // DUT drivers
  ////////////////////////////////
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge gpu_clk);
    while (!idle && n < 4 * `GPU_FB_WORDS) begin
      @(negedge gpu_clk);
      n++;
    end
    check_flag("idle", idle, 1'b1);
  endtask

  task automatic send_vertex(input vertex_t v);
    logic taken;
    int   n;
    taken = 1'b0;
    n     = 0;
    repeat ($urandom % 3) @(posedge gpu_clk);  // Random gap
    @(posedge gpu_clk);
    vertex_valid <= 1'b1;
    vertex       <= v;
    while (!taken && n < 4 * `GPU_FB_WORDS) begin
      @(negedge gpu_clk);
      taken = vertex_ready;
      @(posedge gpu_clk);
      n++;
    end
    check_flag("vertex_ready", taken, 1'b1);
    vertex_valid <= 1'b0;
  endtask

  task automatic pulse_clear();
    int n;
    n = 0;
    @(posedge gpu_clk);
    clear <= 1'b1;
    @(posedge gpu_clk);
    clear <= 1'b0;
    @(negedge gpu_clk);
    check_flag("idle", idle, 1'b0);
    while (!idle && n < 4 * `GPU_FB_WORDS) begin
      check_flag("vertex_ready", vertex_ready, 1'b0);  // Held off by the sweep
      @(negedge gpu_clk);
      n++;
    end
    check_flag("idle", idle, 1'b1);
  endtask

  task automatic pulse_swap();
    @(posedge gpu_clk);
    swap <= 1'b1;
    @(posedge gpu_clk);
    swap <= 1'b0;
  endtask

  task automatic read_back(input int r);
    fb_word_t probe;
    probe = '{z: 8'(SCENE_TAB[r][6]), rgb: 12'(SCENE_TAB[r][7])};
    for (int y = 0; y < H; y++) begin
      for (int x = 0; x < W; x++) begin
        @(posedge gpu_clk);
        rd_x <= 5'(x);
        rd_y <= 5'(y);
        @(posedge gpu_clk);
        @(negedge gpu_clk);
        check_word(rd_data, mbank[mfront][y * W + x], x, y);
        if (x == SCENE_TAB[r][4] && y == SCENE_TAB[r][5]) check_word(rd_data, probe, x, y);
      end
    end
  endtask

  initial begin
    repeat (NROW * 40 * `GPU_FB_WORDS) @(posedge gpu_clk);
    abort_run("Watchdog timeout, the scenes did not finish in time");
  end

  initial begin
    int      id;
    int      t;
    vertex_t v;
    rst_in       = 1'b1;
    vertex_valid = 1'b0;
    vertex       = '0;
    clear        = 1'b0;
    swap         = 1'b0;
    rd_x         = '0;
    rd_y         = '0;
    mfront       = 1'b0;
    id           = 0;
    void'($urandom(32'h1874));
    repeat (2) @(posedge gpu_clk);
    rst_in <= 1'b0;
    wait_idle();

    for (int r = 0; r < NROW; r++) begin
      if (SCENE_TAB[r][0] != 0) begin
        pulse_clear();
        blank_back();
      end
      for (int n = 0; n < SCENE_TAB[r][3]; n++) begin
        t = SCENE_TAB[r][2] + n;
        for (int k = 0; k < 3; k++) begin
          v = '{x: 5'(TRI_TAB[t][2*k]), y: 5'(TRI_TAB[t][2*k+1]), z: 8'(TRI_TAB[t][6+k])};
          send_vertex(v);
        end
        draw_expected(t, id);
        id++;  // Numbers run on across scenes
      end
      wait_idle();
      if (SCENE_TAB[r][1] != 0) begin
        pulse_swap();
        mfront = !mfront;
      end
      read_back(r);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: list.f
+incdir+include
logic/gpu_pkg.sv
logic/triangle_assembler.sv
logic/rasterizer.sv
logic/fragment_shader.sv
logic/framebuffer.sv
logic/gpu_top.sv
bench/gpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the verdict
cd "$(dirname "$0")" &&
  verilator --binary --timing -j 0 --top-module gpu_tb -f list.f &&
  ./obj_dir/Vgpu_tb ||
  { echo "simulation did not pass"; exit 1; }
